//--- Bender.yml
package:
  name: fetch_path

sources:
  - fetch_pkg.sv
  - imem.sv
  - fetch_unit.sv
  - fetch_queue.sv
  - issue_port.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_checker.sv
      - tb_fetch.sv

//--- fetch_checker.sv
/*
  Fetch path checker
  Byte model of the instruction memory fed from observed stores
  Expected pc with reset and redirect handling
  Entry compare and four-phase handshake watch, with result counts
*/
`timescale 1ns/1ns

module fetch_checker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fetch_pkg::store_req_t        store,
  input  logic                         redirect,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  input  logic                         req,
  input  fetch_pkg::fetch_entry_t      issue,
  input  logic                         ack,
  output int                           checked,
  output int                           errors
);
  import fetch_pkg::*;

  logic [7:0]        model_mem [MEM_SIZE];
  logic [ADDR_W-1:0] exp_pc;
  logic              req_q;
  logic              ack_q;
  logic              open;              // From req rise until ack falls
  logic              first_after;       // Next entry follows a redirect
  fetch_entry_t      held;

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      model_mem[i] = NOP_WORD[8*(i%4) +: 8];  // Little-endian NOP fill
    end
    checked = 0;
    errors  = 0;
  end

  // Four bytes from the halfword base, wrapping at the top
  function automatic logic [31:0] read_word(input logic [ADDR_W-1:0] pc);
    logic [31:0] word;
    int          base;
    base = int'(pc) & ~1;
    for (int i = 0; i < 4; i++) begin
      word[8*i +: 8] = model_mem[(base + i) % MEM_SIZE];
    end
    return word;
  endfunction

  function automatic void apply_store();
    int a;
    a = int'(store.addr);
    case (store.size)
      STORE_B: model_mem[a] = store.data[7:0];
      STORE_H: begin
        model_mem[a]                  = store.data[7:0];
        model_mem[(a + 1) % MEM_SIZE] = store.data[15:8];
      end
      STORE_W: begin
        a = a & ~3;                     // Word lands on its word boundary
        for (int i = 0; i < 4; i++) begin
          model_mem[a + i] = store.data[8*i +: 8];
        end
      end
      default: ;
    endcase
  endfunction

  function automatic void check_entry();
    fetch_entry_t expected;
    logic [31:0]  word;
    word                = read_word(exp_pc);
    expected.pc         = exp_pc;
    expected.compressed = (word[1:0] != 2'b11);   // Only 11 marks 32 bits
    expected.instr      = expected.compressed ? {16'h0000, word[15:0]} : word;
    checked++;
    if (first_after && issue.pc != exp_pc) begin
      errors++;
      $display("Error at %0t ns: first entry after redirect at pc %h, target was %h",
               $time, issue.pc, exp_pc);
    end else if (issue != expected) begin
      errors++;
      $display("Error at %0t ns: got pc %h instr %h c %b, expected pc %h instr %h c %b",
               $time, issue.pc, issue.instr, issue.compressed,
               expected.pc, expected.instr, expected.compressed);
    end
    first_after = 1'b0;
    exp_pc      = expected.pc + (expected.compressed ? ADDR_W'(2) : ADDR_W'(4));
  endfunction

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (!rst_n) begin
      exp_pc      = RESET_PC;
      req_q       = 1'b0;
      ack_q       = 1'b0;
      open        = 1'b0;
      first_after = 1'b0;
    end else begin
      if (open && issue != held) begin
        errors++;
        $display("Error at %0t ns: issued entry changed during the handshake", $time);
      end
      // req may only drop once ack is up
      if (req_q && !req && !ack) begin
        errors++;
        $display("Error at %0t ns: req fell before ack rose", $time);
      end
      if (ack_q && !ack) open = 1'b0;   // Handshake closed
      if (req && !req_q) begin
        if (open || ack) begin
          errors++;
          $display("Error at %0t ns: req rose before the last handshake closed", $time);
        end
        check_entry();
        held = issue;
        open = 1'b1;
      end
      if (redirect) begin
        exp_pc      = {redirect_pc[ADDR_W-1:1], 1'b0};
        first_after = 1'b1;
      end
      req_q = req;
      ack_q = ack;
    end
    if (store.valid) apply_store();     // Memory has no reset
  end

endmodule

//--- fetch_pkg.sv
/*
  Shared definitions of the instruction fetch path
  Memory, address and queue sizes, reset pc and NOP fill word
  Store size and issue state enums
  Packed store request and fetch entry structs
*/
package fetch_pkg;

  // Memory geometry, 4 KiB of bytes
  localparam int MEM_SIZE = 4096;
  localparam int ADDR_W   = 12;         // log2 of MEM_SIZE

  localparam logic [ADDR_W-1:0] RESET_PC = '0;

  // Queue sizing
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1; // Count reaches QUEUE_DEPTH

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  // Width of a store, SB / SH / SW
  typedef enum logic [1:0] {
    STORE_B,
    STORE_H,
    STORE_W
  } store_size_e;

  // Store port into the instruction memory, 47 bits
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    store_size_e       size;
  } store_req_t;

  // One fetched instruction, 45 bits
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [31:0]       instr;           // Upper half zero when compressed
    logic              compressed;
  } fetch_entry_t;

  // Four-phase sender states
  typedef enum logic [1:0] {
    IDLE,
    REQ_HIGH,
    WAIT_ACK_LOW
  } issue_state_e;

endpackage

//--- fetch_queue.sv
/*
  Fetch queue
  Circular buffer of QUEUE_DEPTH fetch entries
  Read / write pointers and an entry count
  Push and pop in the same cycle, synchronous flush
*/
`timescale 1ns/1ns

module fetch_queue (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    push,
  input  fetch_pkg::fetch_entry_t push_entry,
  output logic                    full,
  input  logic                    pop,
  output logic                    empty,
  output fetch_pkg::fetch_entry_t head
);
  import fetch_pkg::*;

  fetch_entry_t           slots [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  assign full  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
  assign empty = (count == '0);

  // Ignore a push into a full queue or a pop from an empty one
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign head = slots[rd_ptr];          // Oldest entry

  // Payload storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_entry;
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Redirect drops every queued entry
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;        // Wraps at QUEUE_DEPTH
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

endmodule

//--- fetch_top.sv
/*
  Fetch path top level
  Instruction memory, fetch unit, fetch queue and issue port
*/
`timescale 1ns/1ns

module fetch_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fetch_pkg::store_req_t        store,
  input  logic                         redirect,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  output logic                         req,
  output fetch_pkg::fetch_entry_t      issue,
  input  logic                         ack
);
  import fetch_pkg::*;

  // Memory read path
  logic [ADDR_W-1:0] fetch_addr;
  logic [31:0]       fetch_word;

  // Fetch unit to queue
  logic              push;
  fetch_entry_t      push_entry;
  logic              full;

  // Queue to issue port
  logic              pop;
  logic              empty;
  fetch_entry_t      head;

  imem i_imem (
    .clk        (clk),
    .fetch_addr (fetch_addr),
    .fetch_word (fetch_word),
    .store      (store)
  );

  fetch_unit i_fetch_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .fetch_word  (fetch_word),
    .push        (push),
    .entry       (push_entry),
    .full        (full)
  );

  // Redirect doubles as the queue flush
  fetch_queue i_fetch_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (redirect),
    .push       (push),
    .push_entry (push_entry),
    .full       (full),
    .pop        (pop),
    .empty      (empty),
    .head       (head)
  );

  issue_port i_issue_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .redirect (redirect),
    .empty    (empty),
    .head     (head),
    .pop      (pop),
    .req      (req),
    .issue    (issue),
    .ack      (ack)
  );

endmodule

//--- fetch_unit.sv
/*
  Fetch unit
  Program counter with redirect load and queue-full stall
  Instruction length decode from the two low bits
  Builds one fetch entry per cycle and pushes it into the queue
*/
`timescale 1ns/1ns

module fetch_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_addr,
  input  logic [31:0]                  fetch_word,
  output logic                         push,
  output fetch_pkg::fetch_entry_t      entry,
  input  logic                         full
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc;
  logic              fetch_en;          // Set one cycle after reset release
  logic              is_compressed;
  logic [ADDR_W-1:0] step;

  // Memory is read at the current pc
  assign fetch_addr = pc;

  // Low bits 11 mark a 32-bit instruction, anything else is RVC
  assign is_compressed = (fetch_word[1:0] != 2'b11);
  assign step          = is_compressed ? ADDR_W'(2) : ADDR_W'(4);

  // Entry built in the same cycle as the read
  always_comb begin
    entry.pc         = pc;
    entry.compressed = is_compressed;
    if (is_compressed) begin
      entry.instr = {16'h0000, fetch_word[15:0]};   // Drop the next halfword
    end else begin
      entry.instr = fetch_word;
    end
  end

  // No push while the queue is full or being flushed
  assign push = fetch_en & ~full & ~redirect;

  // Fetch enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
    end
  end

  // Program counter
  // Redirect wins over a normal advance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= {redirect_pc[ADDR_W-1:1], 1'b0};  // Targets are halfword aligned
    end else if (push) begin
      pc <= pc + step;                        // Wraps at MEM_SIZE
    end
    // Full queue holds pc
  end

endmodule

//--- imem.sv
/*
  Writable instruction memory
  Byte array filled with NOP words at start
  Combinational 32-bit read at any halfword boundary, wrapping at the top
  Synchronous byte / halfword / word store port
*/
`timescale 1ns/1ns

module imem (
  input  logic                         clk,
  input  logic [fetch_pkg::ADDR_W-1:0] fetch_addr,
  output logic [31:0]                  fetch_word,
  input  fetch_pkg::store_req_t        store
);
  import fetch_pkg::*;

  // Byte storage, little-endian words
  logic [7:0] mem [MEM_SIZE];

  // Read side addresses
  logic [ADDR_W-1:0] rd_a0;
  logic [ADDR_W-1:0] rd_a1;
  logic [ADDR_W-1:0] rd_a2;
  logic [ADDR_W-1:0] rd_a3;

  // Store side addresses
  logic [ADDR_W-1:0] st_a0;             // Byte / halfword start
  logic [ADDR_W-1:0] st_a1;
  logic [ADDR_W-1:0] wd_a0;             // Word start, bits 1:0 cleared
  logic [ADDR_W-1:0] wd_a1;
  logic [ADDR_W-1:0] wd_a2;
  logic [ADDR_W-1:0] wd_a3;

  // Every word starts as a NOP
  initial begin
    for (int i = 0; i < MEM_SIZE; i += 4) begin
      mem[i]   = NOP_WORD[7:0];
      mem[i+1] = NOP_WORD[15:8];
      mem[i+2] = NOP_WORD[23:16];
      mem[i+3] = NOP_WORD[31:24];
    end
  end

  // Halfword aligned read base
  // Compressed code may start a 32-bit instruction at bit 1 set
  assign rd_a0 = {fetch_addr[ADDR_W-1:1], 1'b0};
  assign rd_a1 = rd_a0 + ADDR_W'(1);
  assign rd_a2 = rd_a0 + ADDR_W'(2);    // Wraps to 0 past the last byte
  assign rd_a3 = rd_a0 + ADDR_W'(3);

  // Four bytes, lowest address in bits 7:0
  assign fetch_word = {mem[rd_a3], mem[rd_a2], mem[rd_a1], mem[rd_a0]};

  // Byte and halfword stores go to their own address
  assign st_a0 = store.addr;
  assign st_a1 = store.addr + ADDR_W'(1);

  // Word stores are forced onto a word boundary
  assign wd_a0 = {store.addr[ADDR_W-1:2], 2'b00};
  assign wd_a1 = wd_a0 + ADDR_W'(1);
  assign wd_a2 = wd_a0 + ADDR_W'(2);
  assign wd_a3 = wd_a0 + ADDR_W'(3);

  // Store port, visible to reads from the next cycle
  always @(posedge clk) begin
    if (store.valid) begin
      case (store.size)
        STORE_B: begin
          mem[st_a0] <= store.data[7:0];
        end
        STORE_H: begin
          mem[st_a0] <= store.data[7:0];
          mem[st_a1] <= store.data[15:8];   // May wrap to byte 0
        end
        STORE_W: begin
          mem[wd_a0] <= store.data[7:0];
          mem[wd_a1] <= store.data[15:8];
          mem[wd_a2] <= store.data[23:16];
          mem[wd_a3] <= store.data[31:24];
        end
        default: begin
          // Unused encoding, memory untouched
        end
      endcase
    end
  end

endmodule

//--- issue_port.sv
/*
  Issue port
  Four-phase req/ack sender toward the decoder
  Pops one queue entry per handshake into a holding register
  Holds off popping while a redirect flushes the queue
*/
`timescale 1ns/1ns

module issue_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    redirect,
  input  logic                    empty,
  input  fetch_pkg::fetch_entry_t head,
  output logic                    pop,
  output logic                    req,
  output fetch_pkg::fetch_entry_t issue,
  input  logic                    ack
);
  import fetch_pkg::*;

  issue_state_e state;
  fetch_entry_t hold;                   // Entry under handshake

  // Take the head only when idle and the queue is not being flushed
  assign pop = (state == IDLE) & ~empty & ~redirect;

  assign req   = (state == REQ_HIGH);
  assign issue = hold;                  // Stable from req rise until ack falls

  // Capture on the pop edge
  always_ff @(posedge clk) begin
    if (pop) begin
      hold <= head;
    end
  end

  // Handshake FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (pop) begin
            state <= REQ_HIGH;          // req high next cycle
          end
        end
        REQ_HIGH: begin
          if (ack) begin
            state <= WAIT_ACK_LOW;      // Drop req
          end
        end
        WAIT_ACK_LOW: begin
          if (!ack) begin
            state <= IDLE;              // Handshake closed
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- sources.f
fetch_pkg.sv
imem.sv
fetch_unit.sv
fetch_queue.sv
issue_port.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

//--- tb_fetch.sv
/*
  Testbench top for the fetch path
  Clock, reset, xorshift stimulus and the four-phase ack responder
  Five tests with a result line each, watchdog and final report
*/
`timescale 1ns/1ns

module tb_fetch;
  import fetch_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int STORE_BASE   = 'h200;  // Region rewritten in test 2
  localparam int STORE_SPAN   = 128;
  localparam int STORE_COUNT  = 48;
  localparam int JUMPS        = 8;      // Redirects in test 4
  localparam int TOTAL_ITEMS  = 20 + 41 + 60 + JUMPS * 7 + 3 * 7;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 40;

  logic              clk;
  logic              rst_n;
  store_req_t        store;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;
  logic              req;
  fetch_entry_t      issue;
  logic              ack;
  logic [31:0]       rng_state;
  int                checked;
  int                errors;
  int                mark_checked;
  int                mark_errors;

  fetch_top i_dut (.clk(clk), .rst_n(rst_n), .store(store), .redirect(redirect),
                   .redirect_pc(redirect_pc), .req(req), .issue(issue), .ack(ack));

  fetch_checker i_checker (.clk(clk), .rst_n(rst_n), .store(store), .redirect(redirect),
                           .redirect_pc(redirect_pc), .req(req), .issue(issue), .ack(ack),
                           .checked(checked), .errors(errors));

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int random_below(input int limit);
    return int'(next_random() % limit);
  endfunction

  // Decoder side, random wait before each ack edge
  task automatic run_items(input int count, input int max_delay);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      while (!req) @(negedge clk);
      repeat (random_below(max_delay + 1)) @(posedge clk);
      @(posedge clk);
      ack <= 1'b1;
      @(negedge clk);
      while (req) @(negedge clk);
      repeat (random_below(max_delay + 1)) @(posedge clk);
      @(posedge clk);
      ack <= 1'b0;
    end
  endtask

  // One handshake first, so req is low and the port idle during the flush
  task automatic redirect_to(input logic [ADDR_W-1:0] target);
    run_items(1, 0);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  task automatic write_mem(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input store_size_e size);
    @(posedge clk);
    store.valid <= 1'b1;
    store.addr  <= addr;
    store.data  <= data;
    store.size  <= size;
    @(posedge clk);
    store.valid <= 1'b0;
  endtask

  task automatic finish_test(input int number, input string name);
    $display("Test %0d %s done: %0d entries, %0d errors", number, name,
             checked - mark_checked, errors - mark_errors);
    mark_checked = checked;
    mark_errors  = errors;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Run timed out after %0d cycles with handshakes still open", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    store = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    ack = 1'b0;
    rng_state = 32'd76;
    mark_checked = 0;
    mark_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    run_items(20, 2);                   // NOPs from pc 0
    finish_test(1, "reset NOP stream");

    for (int i = 0; i < STORE_COUNT; i++) begin
      write_mem(ADDR_W'(STORE_BASE + random_below(STORE_SPAN)), next_random(),
                store_size_e'(random_below(3)));
    end
    write_mem(ADDR_W'(STORE_BASE), 32'h0000_4501, STORE_H);       // c.li a0, 0
    write_mem(ADDR_W'(STORE_BASE + 2), 32'h0000_0513, STORE_H);   // 32-bit at bit 1 set
    write_mem(ADDR_W'(STORE_BASE + 4), 32'h0000_02a0, STORE_H);
    redirect_to(ADDR_W'(STORE_BASE));
    run_items(40, 2);
    finish_test(2, "stores and mixed lengths");

    run_items(60, 5);
    finish_test(3, "back-pressure");

    for (int i = 0; i < JUMPS; i++) begin
      redirect_to(ADDR_W'(2 * random_below(1536)));   // Even targets below 0xC00
      run_items(1 + random_below(6), 5);
    end
    finish_test(4, "random redirects");

    redirect_to(ADDR_W'(MEM_SIZE - 4));              // NOP then pc 0
    run_items(6, 1);
    write_mem(ADDR_W'(MEM_SIZE - 2), 32'h0000_4501, STORE_H);
    redirect_to(ADDR_W'(MEM_SIZE - 2));              // RVC then pc 0
    run_items(6, 1);
    write_mem(ADDR_W'(MEM_SIZE - 2), 32'h0000_0513, STORE_H);
    redirect_to(ADDR_W'(MEM_SIZE - 2));              // Word read wraps to byte 0
    run_items(6, 1);
    finish_test(5, "wraparound");

    $display("Checked %0d entries, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
